// ==== warp_sched.f ====
verilog/warp_sched_pkg.sv
verilog/warp_table.sv
verilog/barrier_unit.sv
verilog/warp_select.sv
verilog/pending_tracker.sv
verilog/warp_sched.sv
testbench/warp_sched_checker.sv
testbench/warp_sched_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the warp scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f warp_sched.f \
    --top-module warp_sched_tb \
    -o warp_sched_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/warp_sched_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx ">>> PASS" <<< "$output"; then
    exit 0
fi
exit 1

// ==== testbench/warp_sched_tb.sv ====
module warp_sched_tb;

    localparam int num_tests = 5;
    localparam logic [31:0] start_pc = 32'h0000_2400;

    logic                                clk;
    logic                                reset;
    warp_sched_pkg::warp_ctl_t           warp_ctl;
    warp_sched_pkg::decode_fb_t          decode_fb;
    warp_sched_pkg::branch_t [1:0]       branch;
    logic                                issue_valid;
    warp_sched_pkg::wid_t                issue_wid;
    warp_sched_pkg::wmask_t              commit_mask;
    logic                                sched_ready;
    logic                                sched_valid;
    warp_sched_pkg::sched_out_t          sched_out;
    logic                                busy;
    int                                  errors;
    int                                  checks;

    int         seed;
    int         cycle;
    int         test_id;
    int         taken_count;
    int         arrivals;
    int         quiet;
    int         issued [4];
    logic [3:0] live;
    logic [3:0] seen;
    bit         spawned;
    // items handed to the decode stage, with the cycle their feedback is due
    warp_sched_pkg::wid_t taken_wid [$];
    int                   taken_due [$];

    warp_sched #(.STARTUP_PC(start_pc)) dut0 (
        .clk(clk), .reset(reset), .warp_ctl(warp_ctl), .decode_fb(decode_fb),
        .branch(branch), .issue_valid(issue_valid), .issue_wid(issue_wid),
        .commit_mask(commit_mask), .sched_ready(sched_ready),
        .sched_valid(sched_valid), .sched_out(sched_out), .busy(busy)
    );

    warp_sched_checker #(.STARTUP_PC(start_pc)) checker0 (
        .clk(clk), .reset(reset), .warp_ctl(warp_ctl), .decode_fb(decode_fb),
        .branch(branch), .issue_valid(issue_valid), .issue_wid(issue_wid),
        .commit_mask(commit_mask), .sched_valid(sched_valid),
        .sched_ready(sched_ready), .sched_out(sched_out), .busy(busy),
        .errors(errors), .checks(checks)
    );

    always #10 clk = ~clk;

    function automatic int unsigned pick_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    always @(posedge clk) begin
        cycle++;
        if (!reset && sched_valid && sched_ready) begin
            taken_wid.push_back(sched_out.wid);
            taken_due.push_back(cycle + 1 + int'(pick_below(4)));
            taken_count++;
            if (test_id == 4 && arrivals == 4) seen[sched_out.wid] = 1'b1;
        end
    end

    // the decode stage's answer to one taken item
    task automatic send_feedback(warp_sched_pkg::wid_t w);
        int unsigned r;
        int unsigned blk;
        r = pick_below(10);
        if (test_id == 3 && !spawned) begin
            warp_ctl.valid                = 1'b1;
            warp_ctl.wid                  = w;
            warp_ctl.op                   = warp_sched_pkg::op_wspawn;
            warp_ctl.payload.wspawn.wmask = 4'b1110;
            warp_ctl.payload.wspawn.pc    = 32'($random(seed)) & ~32'h3;
            spawned = 1;
            live    = 4'b1111;
        end else if (test_id == 4 && arrivals < 4) begin
            warp_ctl.valid                   = 1'b1;
            warp_ctl.wid                     = w;
            warp_ctl.op                      = warp_sched_pkg::op_barrier;
            warp_ctl.payload.barrier.id      = 2'd1;
            warp_ctl.payload.barrier.size_m1 = 2'd3;
            arrivals++;
        end else if (test_id == 5 || r < 2) begin
            warp_ctl.valid             = 1'b1;
            warp_ctl.wid               = w;
            warp_ctl.op                = warp_sched_pkg::op_tmc;
            warp_ctl.payload.tmc.tmask = (test_id == 5) ? 4'd0 : 4'(pick_below(15) + 1);
            if (test_id == 5) live[w] = 1'b0;
        end else if (r < 5) begin
            blk                = pick_below(2);
            branch[blk].valid  = 1'b1;
            branch[blk].wid    = w;
            branch[blk].taken  = 1'(pick_below(2));
            branch[blk].dest   = 32'($random(seed)) & ~32'h1;
        end else begin
            decode_fb.valid  = 1'b1;
            decode_fb.wid    = w;
            decode_fb.is_rvc = 1'(pick_below(2));
            decode_fb.stall  = (pick_below(4) == 0);
            decode_fb.unlock = 1'b1;
        end
    endtask

    task automatic drive_cycle();
        warp_sched_pkg::wid_t w;
        bit                   drained;
        @(negedge clk);
        warp_ctl    = '0;
        decode_fb   = '0;
        branch      = '0;
        issue_valid = 1'b0;
        commit_mask = '0;
        sched_ready = (pick_below(4) != 0);
        // a commit only retires what was issued before this cycle
        for (int i = 0; i < 4; i++) begin
            if (issued[i] > 0 && pick_below(2) == 0) begin
                commit_mask[i] = 1'b1;
                issued[i]--;
            end
        end
        if (!(test_id == 5 && live == 4'b0) && pick_below(2) == 0) begin
            issue_valid = 1'b1;
            issue_wid   = warp_sched_pkg::wid_t'(pick_below(4));
            issued[issue_wid]++;
        end
        if (taken_wid.size() > 0 && taken_due[0] <= cycle) begin
            w = taken_wid.pop_front();
            void'(taken_due.pop_front());
            send_feedback(w);
        end
        drained = (issued[0] == 0 && issued[1] == 0 && issued[2] == 0 && issued[3] == 0);
        quiet = (test_id == 5 && live == 4'b0 && drained) ? quiet + 1 : 0;
    endtask

    function automatic bit test_done(int t, int start);
        case (t)
            1:       return taken_count > start;
            2:       return taken_count >= start + 24;
            3:       return taken_count >= start + 40;
            4:       return seen == 4'b1111;
            default: return quiet >= 8;
        endcase
    endfunction

    initial begin
        #(num_tests * 200 * 20);
        $display("timeout: run did not finish within %0d cycles", num_tests * 200);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int start;
        int start_cycle;
        int start_errors;
        seed        = 32'h7b8e_ba46;
        clk         = 1'b0;
        reset       = 1'b1;
        warp_ctl    = '0;
        decode_fb   = '0;
        branch      = '0;
        issue_valid = 1'b0;
        issue_wid   = '0;
        commit_mask = '0;
        sched_ready = 1'b0;
        cycle       = 0;
        test_id     = 0;
        taken_count = 0;
        arrivals    = 0;
        quiet       = 0;
        live        = 4'b0001;
        seen        = '0;
        spawned     = 0;
        for (int i = 0; i < 4; i++) issued[i] = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        for (int t = 1; t <= num_tests; t++) begin
            test_id      = t;
            start        = taken_count;
            start_cycle  = cycle;
            start_errors = errors;
            do begin
                drive_cycle();
            end while (!test_done(t, start));
            $display("test %0d finished after %0d cycles with %0d errors",
                     t, cycle - start_cycle, errors - start_errors);
        end
        $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/warp_sched_checker.sv ====
module warp_sched_checker #(
    parameter int NUM_ALU_BLOCKS = warp_sched_pkg::num_alu_blocks,
    parameter logic [31:0] STARTUP_PC = warp_sched_pkg::startup_pc
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  warp_sched_pkg::warp_ctl_t                    warp_ctl,
    input  warp_sched_pkg::decode_fb_t                   decode_fb,
    input  warp_sched_pkg::branch_t [NUM_ALU_BLOCKS-1:0] branch,
    input  logic                                         issue_valid,
    input  warp_sched_pkg::wid_t                         issue_wid,
    input  warp_sched_pkg::wmask_t                       commit_mask,
    input  logic                                         sched_valid,
    input  logic                                         sched_ready,
    input  warp_sched_pkg::sched_out_t                   sched_out,
    input  logic                                         busy,
    output int                                           errors,
    output int                                           checks
);

    // model of the warp table
    logic [3:0][31:0] pcs;
    logic [3:0][3:0]  tmasks;
    logic [3:0]       active;
    logic [3:0]       outstanding;
    logic [3:0]       waiting;
    // freed by a barrier and not transferred since
    logic [3:0]       released;
    logic [3:0]       bar_mask [4];
    logic [1:0]       bar_ctr [4];
    int               pend [4];
    bit               first_seen;
    int               quiet;

    task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic fail_plain(string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_item();
        int w;
        w = int'(sched_out.wid);
        if (!first_seen) begin
            compare("sched_out.wid", 32'(sched_out.wid), 32'd0);
            first_seen = 1;
        end
        if (!active[w]) fail_plain($sformatf("warp %0d transferred while inactive", w));
        if (waiting[w]) fail_plain($sformatf("warp %0d left a barrier too early", w));
        if (outstanding[w]) fail_plain($sformatf("warp %0d transferred twice without unlock", w));
        // warps freed together are picked lowest index first
        if (released[w]) begin
            if ((released & ((4'b1 << w) - 4'b1)) != 4'b0) begin
                fail_plain($sformatf("warp %0d transferred ahead of a lower released warp", w));
            end
            released[w] = 1'b0;
        end
        compare("sched_out.pc", sched_out.pc, pcs[w]);
        compare("sched_out.tmask", 32'(sched_out.tmask), 32'(tmasks[w]));
        outstanding[w] = 1'b1;
    endtask

    task automatic apply_events();
        int         w;
        int         id;
        logic [3:0] rel;
        if (decode_fb.valid) begin
            w = int'(decode_fb.wid);
            if (!decode_fb.stall) pcs[w] = pcs[w] + (decode_fb.is_rvc ? 32'd2 : 32'd4);
            if (decode_fb.unlock) outstanding[w] = 1'b0;
        end
        if (warp_ctl.valid) begin
            w = int'(warp_ctl.wid);
            case (warp_ctl.op)
                warp_sched_pkg::op_tmc: begin
                    tmasks[w]      = warp_ctl.payload.tmc.tmask;
                    active[w]      = (warp_ctl.payload.tmc.tmask != 4'b0);
                    outstanding[w] = 1'b0;
                end
                warp_sched_pkg::op_wspawn: begin
                    // spawned warps are idle, so the early update is not visible
                    for (int i = 0; i < 4; i++) begin
                        if (warp_ctl.payload.wspawn.wmask[i]) begin
                            active[i] = 1'b1;
                            tmasks[i] = 4'd1;
                            pcs[i]    = warp_ctl.payload.wspawn.pc;
                        end
                    end
                    outstanding[w] = 1'b0;
                end
                warp_sched_pkg::op_barrier: begin
                    id = int'(warp_ctl.payload.barrier.id);
                    rel = bar_mask[id] | (4'b1 << w);
                    if (bar_ctr[id] == warp_ctl.payload.barrier.size_m1) begin
                        outstanding  = outstanding & ~rel;
                        waiting      = waiting & ~rel;
                        released     = released | rel;
                        bar_mask[id] = 4'b0;
                        bar_ctr[id]  = 2'd0;
                    end else begin
                        bar_mask[id] = rel;
                        waiting      = waiting | rel;
                        bar_ctr[id]  = bar_ctr[id] + 2'd1;
                    end
                end
                default: ;
            endcase
        end
        for (int b = 0; b < NUM_ALU_BLOCKS; b++) begin
            if (branch[b].valid) begin
                if (branch[b].taken) pcs[branch[b].wid] = branch[b].dest;
                outstanding[branch[b].wid] = 1'b0;
            end
        end
        for (int i = 0; i < 4; i++) begin
            if (issue_valid && int'(issue_wid) == i) pend[i]++;
            if (commit_mask[i]) pend[i]--;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pcs         = '0;
            pcs[0]      = STARTUP_PC;
            tmasks      = '0;
            tmasks[0]   = 4'd1;
            active      = 4'b0001;
            outstanding = '0;
            waiting     = '0;
            released    = '0;
            for (int i = 0; i < 4; i++) begin
                bar_mask[i] = '0;
                bar_ctr[i]  = '0;
                pend[i]     = 0;
            end
            first_seen = 0;
            quiet      = 0;
            errors     = 0;
            checks     = 0;
        end else begin
            if (sched_valid && sched_ready) check_item();
            // idle and drained, so busy must have dropped
            if (quiet >= 2) compare("busy", 32'(busy), 32'd0);
            apply_events();
            if (active == 4'b0 && pend[0] == 0 && pend[1] == 0 && pend[2] == 0 && pend[3] == 0)
                quiet++;
            else
                quiet = 0;
        end
    end

endmodule

// ==== verilog/warp_sched.sv ====
module warp_sched #(
    parameter int NUM_WARPS      = warp_sched_pkg::num_warps,
    parameter int NUM_THREADS    = warp_sched_pkg::num_threads,
    parameter int NUM_BARRIERS   = warp_sched_pkg::num_barriers,
    parameter int NUM_ALU_BLOCKS = warp_sched_pkg::num_alu_blocks,
    parameter logic [warp_sched_pkg::pc_bits-1:0] STARTUP_PC = warp_sched_pkg::startup_pc
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  warp_sched_pkg::warp_ctl_t                    warp_ctl,
    input  warp_sched_pkg::decode_fb_t                   decode_fb,
    input  warp_sched_pkg::branch_t [NUM_ALU_BLOCKS-1:0] branch,
    input  logic                                         issue_valid,
    input  warp_sched_pkg::wid_t                         issue_wid,
    input  warp_sched_pkg::wmask_t                       commit_mask,
    input  logic                                         sched_ready,
    output logic                                         sched_valid,
    output warp_sched_pkg::sched_out_t                   sched_out,
    output logic                                         busy
);

    warp_sched_pkg::wmask_t                            active;
    warp_sched_pkg::wmask_t                            stalled;
    logic [NUM_WARPS-1:0][warp_sched_pkg::pc_bits-1:0] pcs;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0]             tmasks;
    logic                                              pick;
    warp_sched_pkg::wid_t                              pick_wid;
    warp_sched_pkg::wmask_t                            release_mask;

    warp_table #(
        .NUM_WARPS      (NUM_WARPS),
        .NUM_THREADS    (NUM_THREADS),
        .NUM_ALU_BLOCKS (NUM_ALU_BLOCKS),
        .STARTUP_PC     (STARTUP_PC)
    ) table0 (
        .clk          (clk),
        .reset        (reset),
        .warp_ctl     (warp_ctl),
        .decode_fb    (decode_fb),
        .branch       (branch),
        .release_mask (release_mask),
        .pick         (pick),
        .pick_wid     (pick_wid),
        .active       (active),
        .stalled      (stalled),
        .pcs          (pcs),
        .tmasks       (tmasks)
    );

    // release_mask is already zero when nothing is released
    barrier_unit #(
        .NUM_WARPS    (NUM_WARPS),
        .NUM_BARRIERS (NUM_BARRIERS)
    ) barrier0 (
        .clk           (clk),
        .reset         (reset),
        .warp_ctl      (warp_ctl),
        .release_mask  (release_mask),
        .release_valid ()
    );

    warp_select #(
        .NUM_WARPS   (NUM_WARPS),
        .NUM_THREADS (NUM_THREADS)
    ) select0 (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .stalled     (stalled),
        .pcs         (pcs),
        .tmasks      (tmasks),
        .pick        (pick),
        .pick_wid    (pick_wid),
        .sched_valid (sched_valid),
        .sched_ready (sched_ready),
        .sched_out   (sched_out)
    );

    pending_tracker #(
        .NUM_WARPS (NUM_WARPS)
    ) pending0 (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_wid   (issue_wid),
        .commit_mask (commit_mask),
        .active      (active),
        .busy        (busy)
    );

endmodule

// ==== verilog/pending_tracker.sv ====
module pending_tracker #(
    parameter int NUM_WARPS = warp_sched_pkg::num_warps
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_valid,
    input  warp_sched_pkg::wid_t   issue_wid,
    input  warp_sched_pkg::wmask_t commit_mask,
    input  warp_sched_pkg::wmask_t active,
    output logic                   busy
);

    localparam int cnt_w = warp_sched_pkg::pending_bits;

    logic [NUM_WARPS-1:0][cnt_w-1:0] counts;
    logic [NUM_WARPS-1:0]            incr;
    logic                            any_pending;

    always_comb begin
        for (int i = 0; i < NUM_WARPS; i++) begin
            incr[i] = issue_valid && (issue_wid == warp_sched_pkg::wid_t'(i));
        end
    end

    assign any_pending = (counts != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            counts <= '0;
            busy   <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                // issue and commit together leave the count alone
                case ({incr[i], commit_mask[i]})
                    2'b10:   counts[i] <= counts[i] + cnt_w'(1);
                    2'b01:   counts[i] <= counts[i] - cnt_w'(1);
                    default: counts[i] <= counts[i];
                endcase
            end
            busy <= (active != '0) || any_pending;
        end
    end

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_underflow_check
        no_underflow: assert property (
            @(posedge clk) disable iff (reset)
            (commit_mask[w] && !incr[w]) |-> (counts[w] != '0)
        ) else $error("warp %0d committed with nothing pending", w);
    end

endmodule

// ==== verilog/warp_select.sv ====
module warp_select #(
    parameter int NUM_WARPS   = warp_sched_pkg::num_warps,
    parameter int NUM_THREADS = warp_sched_pkg::num_threads
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  warp_sched_pkg::wmask_t                            active,
    input  warp_sched_pkg::wmask_t                            stalled,
    input  logic [NUM_WARPS-1:0][warp_sched_pkg::pc_bits-1:0] pcs,
    input  logic [NUM_WARPS-1:0][NUM_THREADS-1:0]             tmasks,
    output logic                                              pick,
    output warp_sched_pkg::wid_t                              pick_wid,
    output logic                                              sched_valid,
    input  logic                                              sched_ready,
    output warp_sched_pkg::sched_out_t                        sched_out
);

    warp_sched_pkg::wmask_t     ready_warps;
    logic                       any_ready;
    warp_sched_pkg::sched_out_t pick_data;

    // second entry of the output buffer
    logic                       skid_valid;
    warp_sched_pkg::sched_out_t skid_data;
    logic                       out_free;

    assign ready_warps = active & ~stalled;

    // lowest index wins, so scan downward and let later hits overwrite
    always_comb begin
        any_ready = 1'b0;
        pick_wid  = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                any_ready = 1'b1;
                pick_wid  = warp_sched_pkg::wid_t'(i);
            end
        end
    end

    assign pick = any_ready && !skid_valid;

    assign pick_data.wid   = pick_wid;
    assign pick_data.pc    = pcs[pick_wid];
    assign pick_data.tmask = tmasks[pick_wid];

    assign out_free = !sched_valid || sched_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            sched_valid <= 1'b0;
            skid_valid  <= 1'b0;
        end else if (out_free) begin
            sched_valid <= skid_valid || pick;
            skid_valid  <= 1'b0;
        end else if (pick) begin
            skid_valid  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            sched_out <= skid_valid ? skid_data : pick_data;
        end else if (pick) begin
            skid_data <= pick_data;
        end
    end

    hold_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        (sched_valid && !sched_ready) |=> (sched_valid && $stable(sched_out))
    ) else $error("sched_out changed under back-pressure");

endmodule

// ==== verilog/barrier_unit.sv ====
module barrier_unit #(
    parameter int NUM_WARPS    = warp_sched_pkg::num_warps,
    parameter int NUM_BARRIERS = warp_sched_pkg::num_barriers
) (
    input  logic                      clk,
    input  logic                      reset,
    input  warp_sched_pkg::warp_ctl_t warp_ctl,
    output warp_sched_pkg::wmask_t    release_mask,
    output logic                      release_valid
);

    // one spare bit so an overrun would show up in the counter
    localparam int ctr_w = $clog2(NUM_WARPS) + 1;

    logic [NUM_BARRIERS-1:0][ctr_w-1:0]         ctrs;
    warp_sched_pkg::wmask_t [NUM_BARRIERS-1:0]  masks;

    logic                   is_barrier;
    logic [1:0]             bar_id;
    logic [1:0]             size_m1;
    logic                   last_arrival;
    warp_sched_pkg::wmask_t arrive_mask;

    assign is_barrier = warp_ctl.valid && (warp_ctl.op == warp_sched_pkg::op_barrier);
    assign bar_id     = warp_ctl.payload.barrier.id;
    assign size_m1    = warp_ctl.payload.barrier.size_m1;

    // waiting warps plus the one arriving now
    always_comb begin
        arrive_mask               = masks[bar_id];
        arrive_mask[warp_ctl.wid] = 1'b1;
    end

    assign last_arrival  = (ctrs[bar_id] == ctr_w'(size_m1));
    assign release_valid = is_barrier && last_arrival;
    assign release_mask  = release_valid ? arrive_mask : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrs  <= '0;
            masks <= '0;
        end else if (is_barrier) begin
            if (last_arrival) begin
                ctrs[bar_id]  <= '0;
                masks[bar_id] <= '0;
            end else begin
                ctrs[bar_id]  <= ctrs[bar_id] + ctr_w'(1);
                masks[bar_id] <= arrive_mask;
            end
        end
    end

    // a size_m1 above the live warp count would leave this counter climbing
    for (genvar b = 0; b < NUM_BARRIERS; b++) begin : g_ctr_check
        ctr_in_range: assert property (
            @(posedge clk) disable iff (reset)
            ctrs[b] <= ctr_w'(NUM_WARPS - 1)
        ) else $error("barrier %0d counter overrun: %0d", b, ctrs[b]);
    end

endmodule

// ==== verilog/warp_table.sv ====
module warp_table #(
    parameter int NUM_WARPS      = warp_sched_pkg::num_warps,
    parameter int NUM_THREADS    = warp_sched_pkg::num_threads,
    parameter int NUM_ALU_BLOCKS = warp_sched_pkg::num_alu_blocks,
    parameter logic [warp_sched_pkg::pc_bits-1:0] STARTUP_PC = warp_sched_pkg::startup_pc
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  warp_sched_pkg::warp_ctl_t                      warp_ctl,
    input  warp_sched_pkg::decode_fb_t                     decode_fb,
    input  warp_sched_pkg::branch_t [NUM_ALU_BLOCKS-1:0]   branch,
    input  warp_sched_pkg::wmask_t                         release_mask,
    input  logic                                           pick,
    input  warp_sched_pkg::wid_t                           pick_wid,
    output warp_sched_pkg::wmask_t                         active,
    output warp_sched_pkg::wmask_t                         stalled,
    output logic [NUM_WARPS-1:0][warp_sched_pkg::pc_bits-1:0] pcs,
    output logic [NUM_WARPS-1:0][NUM_THREADS-1:0]          tmasks
);

    localparam int pc_w = warp_sched_pkg::pc_bits;

    warp_sched_pkg::wmask_t               active_n;
    warp_sched_pkg::wmask_t               stalled_n;
    logic [NUM_WARPS-1:0][pc_w-1:0]       pcs_n;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0] tmasks_n;

    // wspawn waits here until a single warp is left running
    logic                   wspawn_valid;
    warp_sched_pkg::wmask_t wspawn_wmask;
    logic [pc_w-1:0]        wspawn_pc;
    warp_sched_pkg::wid_t   wspawn_wid;
    logic                   is_single_warp;

    logic ctl_tmc;
    logic ctl_wspawn;
    logic wspawn_apply;

    assign ctl_tmc      = warp_ctl.valid && (warp_ctl.op == warp_sched_pkg::op_tmc);
    assign ctl_wspawn   = warp_ctl.valid && (warp_ctl.op == warp_sched_pkg::op_wspawn);
    assign wspawn_apply = wspawn_valid && is_single_warp;

    always_comb begin
        active_n  = active;
        stalled_n = stalled;
        pcs_n     = pcs;
        tmasks_n  = tmasks;

        if (decode_fb.valid) begin
            if (!decode_fb.stall) begin
                pcs_n[decode_fb.wid] = pcs[decode_fb.wid]
                                     + (decode_fb.is_rvc ? pc_w'(2) : pc_w'(4));
            end
            if (decode_fb.unlock) begin
                stalled_n[decode_fb.wid] = 1'b0;
            end
        end

        if (wspawn_apply) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (wspawn_wmask[i]) begin
                    active_n[i] = 1'b1;
                    tmasks_n[i] = NUM_THREADS'(1);
                    pcs_n[i]    = wspawn_pc;
                end
            end
            stalled_n[wspawn_wid] = 1'b0;
        end

        // an all-zero mask retires the warp
        if (ctl_tmc) begin
            active_n[warp_ctl.wid]  = (warp_ctl.payload.tmc.tmask != '0);
            tmasks_n[warp_ctl.wid]  = warp_ctl.payload.tmc.tmask;
            stalled_n[warp_ctl.wid] = 1'b0;
        end

        stalled_n = stalled_n & ~release_mask;

        for (int i = 0; i < NUM_ALU_BLOCKS; i++) begin
            if (branch[i].valid) begin
                if (branch[i].taken) begin
                    pcs_n[branch[i].wid] = branch[i].dest;
                end
                stalled_n[branch[i].wid] = 1'b0;
            end
        end

        // hold the warp until decode reports back
        if (pick) begin
            stalled_n[pick_wid] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active         <= '0;
            active[0]      <= 1'b1;
            stalled        <= '0;
            pcs            <= '0;
            pcs[0]         <= STARTUP_PC;
            tmasks         <= '0;
            tmasks[0]      <= NUM_THREADS'(1);
            is_single_warp <= 1'b1;
            wspawn_valid   <= 1'b0;
        end else begin
            active         <= active_n;
            stalled        <= stalled_n;
            pcs            <= pcs_n;
            tmasks         <= tmasks_n;
            is_single_warp <= $onehot(active);
            if (wspawn_apply) begin
                wspawn_valid <= 1'b0;
            end
            if (ctl_wspawn) begin
                wspawn_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_wspawn) begin
            wspawn_wmask <= warp_ctl.payload.wspawn.wmask;
            wspawn_pc    <= warp_ctl.payload.wspawn.pc;
            wspawn_wid   <= warp_ctl.wid;
        end
    end

    // selection sees the registered state of this table
    pick_ready_warp: assert property (
        @(posedge clk) disable iff (reset)
        pick |-> (active[pick_wid] && !stalled[pick_wid])
    ) else $error("pick of warp %0d which is not ready", pick_wid);

endmodule

// ==== verilog/warp_sched_pkg.sv ====
package warp_sched_pkg;

    // default sizes, overridden through the top level parameters
    parameter int num_warps      = 4;
    parameter int num_threads    = 4;
    parameter int num_barriers   = 4;
    parameter int num_alu_blocks = 2;
    parameter int pc_bits        = 32;
    parameter int pending_bits   = 12;
    parameter logic [pc_bits-1:0] startup_pc = 32'h0000_1000;

    // the wspawn view is the widest one and sets the payload width
    parameter int ctl_payload_bits = num_warps + pc_bits;

    typedef logic [1:0]             wid_t;
    typedef logic [num_threads-1:0] tmask_t;
    typedef logic [num_warps-1:0]   wmask_t;

    typedef enum logic [1:0] {
        op_none,
        op_tmc,
        op_wspawn,
        op_barrier
    } ctl_op_t;

    typedef struct packed {
        logic [ctl_payload_bits-num_threads-1:0] pad;
        tmask_t                                  tmask;
    } tmc_payload_t;

    typedef struct packed {
        wmask_t             wmask;
        logic [pc_bits-1:0] pc;
    } wspawn_payload_t;

    typedef struct packed {
        logic [ctl_payload_bits-5:0] pad;
        logic [1:0]                  id;
        logic [1:0]                  size_m1;
    } barrier_payload_t;

    // one payload word, decoded according to the opcode
    typedef union packed {
        tmc_payload_t     tmc;
        wspawn_payload_t  wspawn;
        barrier_payload_t barrier;
    } ctl_payload_u;

    typedef struct packed {
        logic         valid;
        wid_t         wid;
        ctl_op_t      op;
        ctl_payload_u payload;
    } warp_ctl_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
        logic is_rvc;
        logic stall;
        logic unlock;
    } decode_fb_t;

    typedef struct packed {
        logic               valid;
        wid_t               wid;
        logic               taken;
        logic [pc_bits-1:0] dest;
    } branch_t;

    typedef struct packed {
        wid_t               wid;
        logic [pc_bits-1:0] pc;
        tmask_t             tmask;
    } sched_out_t;

endpackage
